/* hw/axi_w_channel.sv */
`timescale 1ns/10ps

module axi_w_channel #(
	parameter int DATA_W = 32
) (
	input  logic                         AClk,
	input  logic                         ARst,
	input  logic                         burst_start,
	input  logic [axi_wr_pkg::LEN_W-1:0] burst_len,
	output logic                         burst_done,
	output logic                         fifo_pop,
	input  logic [DATA_W-1:0]            fifo_data,
	input  logic [DATA_W/8-1:0]          fifo_strb,
	input  logic                         fifo_empty,
	output logic [DATA_W-1:0]            WDATA,
	output logic [DATA_W/8-1:0]          WSTRB,
	output logic                         WLAST,
	output logic                         WVALID,
	input  logic                         WREADY
);

	localparam int STRB_W = DATA_W / 8;
	localparam int CNT_W  = axi_wr_pkg::LEN_W + 1;

	// beats still to be popped for the current burst
	logic [CNT_W-1:0] beats_left;

	// last byte sent on every lane
	logic [DATA_W-1:0] lane_hist;
	logic [DATA_W-1:0] merged;

	logic slot_free;

	////////////////////////////////////////
	// pop control
	////////////////////////////////////////

	// slot is free when empty or draining this cycle
	assign slot_free = !WVALID || WREADY;
	assign fifo_pop  = (beats_left != '0) && !fifo_empty && slot_free;

	always_ff @(posedge AClk or negedge ARst) begin
		if (!ARst) begin
			beats_left <= '0;
		end else if (burst_start) begin
			beats_left <= {1'b0, burst_len} + {{axi_wr_pkg::LEN_W{1'b0}}, 1'b1};
		end else if (fifo_pop) begin
			beats_left <= beats_left - 1'b1;
		end
	end

	////////////////////////////////////////
	// lane merge
	////////////////////////////////////////

	// clear strobe repeats the previous byte of that lane
	for (genvar i = 0; i < STRB_W; i++) begin : g_lane
		assign merged[8*i +: 8] = fifo_strb[i] ? fifo_data[8*i +: 8] : lane_hist[8*i +: 8];
	end

	// history starts at zero so unwritten lanes go out as zero
	always_ff @(posedge AClk or negedge ARst) begin
		if (!ARst) begin
			lane_hist <= '0;
		end else if (fifo_pop) begin
			lane_hist <= merged;
		end
	end

	// the history register is also the outgoing beat
	assign WDATA = lane_hist;

	////////////////////////////////////////
	// W handshake
	////////////////////////////////////////

	always_ff @(posedge AClk or negedge ARst) begin
		if (!ARst) begin
			WVALID <= 1'b0;
			WLAST  <= 1'b0;
		end else if (fifo_pop) begin
			WVALID <= 1'b1;
			WLAST  <= (beats_left == {{axi_wr_pkg::LEN_W{1'b0}}, 1'b1});
		end else if (WREADY) begin
			WVALID <= 1'b0;
			WLAST  <= 1'b0;
		end
	end

	always_ff @(posedge AClk) begin
		if (fifo_pop) begin
			WSTRB <= fifo_strb;
		end
	end

	// end of the W phase
	assign burst_done = WVALID && WREADY && WLAST;

	a_last_valid: assert property (@(posedge AClk) disable iff (!ARst)
		WLAST |-> WVALID);

	// AXI rule, beat must hold until accepted
	a_w_stable: assert property (@(posedge AClk) disable iff (!ARst)
		WVALID && !WREADY |=> WVALID && $stable(WDATA) && $stable(WSTRB) && $stable(WLAST));

endmodule

/* hw/axi_wr_ctrl.sv */
`timescale 1ns/10ps

module axi_wr_ctrl #(
	parameter int ADDR_W = 32
) (
	input  logic                          AClk,
	input  logic                          ARst,

	// command port
	input  logic                          cmd_valid,
	output logic                          cmd_ready,
	input  logic [axi_wr_pkg::ID_W-1:0]   cmd_id,
	input  logic [ADDR_W-1:0]             cmd_addr,
	input  logic [axi_wr_pkg::LEN_W-1:0]  cmd_len,
	input  logic [axi_wr_pkg::SIZE_W-1:0] cmd_size,
	input  axi_wr_pkg::burst_e            cmd_burst,

	// AW channel
	output logic [axi_wr_pkg::ID_W-1:0]   AWID,
	output logic [ADDR_W-1:0]             AWADDR,
	output logic [axi_wr_pkg::LEN_W-1:0]  AWLEN,
	output logic [axi_wr_pkg::SIZE_W-1:0] AWSIZE,
	output axi_wr_pkg::burst_e            AWBURST,
	output logic                          AWVALID,
	input  logic                          AWREADY,

	// B channel
	input  logic [axi_wr_pkg::ID_W-1:0]   BID,
	input  axi_wr_pkg::resp_e             BRESP,
	input  logic                          BVALID,
	output logic                          BREADY,

	// response report
	output logic                          rsp_valid,
	output logic [axi_wr_pkg::ID_W-1:0]   rsp_id,
	output axi_wr_pkg::resp_e             rsp_resp,

	// to and from the W channel
	output logic                          burst_start,
	output logic [axi_wr_pkg::LEN_W-1:0]  burst_len,
	input  logic                          burst_done
);

	axi_wr_pkg::wr_state_e state_q;
	axi_wr_pkg::wr_state_e state_d;

	logic cmd_accept;
	logic b_accept;

	////////////////////////////////////////
	// state machine
	////////////////////////////////////////

	always_comb begin
		state_d = state_q;
		case (state_q)
			axi_wr_pkg::IDLE: begin
				if (cmd_valid) begin
					state_d = axi_wr_pkg::ADDR;
				end
			end
			axi_wr_pkg::ADDR: begin
				if (AWREADY) begin
					state_d = axi_wr_pkg::DATA;
				end
			end
			// wait for the last W beat
			axi_wr_pkg::DATA: begin
				if (burst_done) begin
					state_d = axi_wr_pkg::RESP;
				end
			end
			axi_wr_pkg::RESP: begin
				if (BVALID) begin
					state_d = axi_wr_pkg::IDLE;
				end
			end
			default: begin
				state_d = axi_wr_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge AClk or negedge ARst) begin
		if (!ARst) begin
			state_q <= axi_wr_pkg::IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// decoded handshakes
	assign cmd_ready  = (state_q == axi_wr_pkg::IDLE);
	assign cmd_accept = cmd_valid && cmd_ready;
	assign AWVALID    = (state_q == axi_wr_pkg::ADDR);
	assign BREADY     = (state_q == axi_wr_pkg::RESP);
	assign b_accept   = BVALID && BREADY;

	////////////////////////////////////////
	// command register, drives AW
	////////////////////////////////////////

	always_ff @(posedge AClk) begin
		if (cmd_accept) begin
			AWID    <= cmd_id;
			AWADDR  <= cmd_addr;
			AWLEN   <= cmd_len;
			AWSIZE  <= cmd_size;
			AWBURST <= cmd_burst;
		end
	end

	// W phase starts on the AW handshake
	assign burst_start = AWVALID && AWREADY;
	assign burst_len   = AWLEN;

	////////////////////////////////////////
	// response report
	////////////////////////////////////////

	always_ff @(posedge AClk or negedge ARst) begin
		if (!ARst) begin
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= b_accept;
		end
	end

	always_ff @(posedge AClk) begin
		if (b_accept) begin
			rsp_id   <= BID;
			rsp_resp <= BRESP;
		end
	end

	// address phase payload may not move while stalled
	a_aw_stable: assert property (@(posedge AClk) disable iff (!ARst)
		AWVALID && !AWREADY |=> AWVALID && $stable({AWID, AWADDR, AWLEN, AWSIZE, AWBURST}));

endmodule

/* hw/axi_wr_master.sv */
`timescale 1ns/10ps

module axi_wr_master #(
	parameter int ADDR_W     = 32,
	parameter int DATA_W     = 32,
	parameter int FIFO_DEPTH = 16
) (
	input  logic                          AClk,
	input  logic                          ARst,

	// command port
	input  logic                          cmd_valid,
	output logic                          cmd_ready,
	input  logic [axi_wr_pkg::ID_W-1:0]   cmd_id,
	input  logic [ADDR_W-1:0]             cmd_addr,
	input  logic [axi_wr_pkg::LEN_W-1:0]  cmd_len,
	input  logic [axi_wr_pkg::SIZE_W-1:0] cmd_size,
	input  axi_wr_pkg::burst_e            cmd_burst,

	// write data port
	input  logic                          wdata_valid,
	output logic                          wdata_ready,
	input  logic [DATA_W-1:0]             wdata_in,
	input  logic [DATA_W/8-1:0]           wstrb_in,

	// AXI AW
	output logic [axi_wr_pkg::ID_W-1:0]   AWID,
	output logic [ADDR_W-1:0]             AWADDR,
	output logic [axi_wr_pkg::LEN_W-1:0]  AWLEN,
	output logic [axi_wr_pkg::SIZE_W-1:0] AWSIZE,
	output axi_wr_pkg::burst_e            AWBURST,
	output logic                          AWVALID,
	input  logic                          AWREADY,

	// AXI W
	output logic [DATA_W-1:0]             WDATA,
	output logic [DATA_W/8-1:0]           WSTRB,
	output logic                          WLAST,
	output logic                          WVALID,
	input  logic                          WREADY,

	// AXI B
	input  logic [axi_wr_pkg::ID_W-1:0]   BID,
	input  axi_wr_pkg::resp_e             BRESP,
	input  logic                          BVALID,
	output logic                          BREADY,

	// response report
	output logic                          rsp_valid,
	output logic [axi_wr_pkg::ID_W-1:0]   rsp_id,
	output axi_wr_pkg::resp_e             rsp_resp
);

	logic                         fifo_full;
	logic                         fifo_empty;
	logic                         fifo_pop;
	logic [DATA_W-1:0]            fifo_data;
	logic [DATA_W/8-1:0]          fifo_strb;
	logic                         burst_start;
	logic [axi_wr_pkg::LEN_W-1:0] burst_len;
	logic                         burst_done;

	// back-pressure only when storage is full
	assign wdata_ready = !fifo_full;

	wdata_fifo #(
		.DATA_W     (DATA_W),
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo (
		.AClk      (AClk),
		.ARst      (ARst),
		.push      (wdata_valid && wdata_ready),
		.push_data (wdata_in),
		.push_strb (wstrb_in),
		.full      (fifo_full),
		.pop       (fifo_pop),
		.pop_data  (fifo_data),
		.pop_strb  (fifo_strb),
		.empty     (fifo_empty)
	);

	axi_wr_ctrl #(
		.ADDR_W (ADDR_W)
	) u_ctrl (
		.AClk        (AClk),
		.ARst        (ARst),
		.cmd_valid   (cmd_valid),
		.cmd_ready   (cmd_ready),
		.cmd_id      (cmd_id),
		.cmd_addr    (cmd_addr),
		.cmd_len     (cmd_len),
		.cmd_size    (cmd_size),
		.cmd_burst   (cmd_burst),
		.AWID        (AWID),
		.AWADDR      (AWADDR),
		.AWLEN       (AWLEN),
		.AWSIZE      (AWSIZE),
		.AWBURST     (AWBURST),
		.AWVALID     (AWVALID),
		.AWREADY     (AWREADY),
		.BID         (BID),
		.BRESP       (BRESP),
		.BVALID      (BVALID),
		.BREADY      (BREADY),
		.rsp_valid   (rsp_valid),
		.rsp_id      (rsp_id),
		.rsp_resp    (rsp_resp),
		.burst_start (burst_start),
		.burst_len   (burst_len),
		.burst_done  (burst_done)
	);

	axi_w_channel #(
		.DATA_W (DATA_W)
	) u_w_channel (
		.AClk        (AClk),
		.ARst        (ARst),
		.burst_start (burst_start),
		.burst_len   (burst_len),
		.burst_done  (burst_done),
		.fifo_pop    (fifo_pop),
		.fifo_data   (fifo_data),
		.fifo_strb   (fifo_strb),
		.fifo_empty  (fifo_empty),
		.WDATA       (WDATA),
		.WSTRB       (WSTRB),
		.WLAST       (WLAST),
		.WVALID      (WVALID),
		.WREADY      (WREADY)
	);

endmodule

/* hw/axi_wr_pkg.sv */
package axi_wr_pkg;

	////////////////////////////////////////
	// field widths
	////////////////////////////////////////

	// transaction id on AW and B
	localparam int ID_W = 4;

	// burst has AWLEN plus one beats
	localparam int LEN_W = 8;

	// bytes per beat as a power of two
	localparam int SIZE_W = 3;

	////////////////////////////////////////
	// encodings
	////////////////////////////////////////

	// AWBURST, carried through unchanged
	typedef enum logic [1:0] {
		FIXED = 2'b00,
		INCR  = 2'b01,
		WRAP  = 2'b10
	} burst_e;

	// BRESP and the response report
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} resp_e;

	// write controller states
	typedef enum logic [1:0] {
		IDLE = 2'b00,
		ADDR = 2'b01,
		DATA = 2'b10,
		RESP = 2'b11
	} wr_state_e;

endpackage

/* hw/wdata_fifo.sv */
`timescale 1ns/10ps

module wdata_fifo #(
	parameter int DATA_W     = 32,
	parameter int FIFO_DEPTH = 16
) (
	input  logic                AClk,
	input  logic                ARst,
	input  logic                push,
	input  logic [DATA_W-1:0]   push_data,
	input  logic [DATA_W/8-1:0] push_strb,
	output logic                full,
	input  logic                pop,
	output logic [DATA_W-1:0]   pop_data,
	output logic [DATA_W/8-1:0] pop_strb,
	output logic                empty
);

	localparam int STRB_W = DATA_W / 8;
	localparam int AW     = $clog2(FIFO_DEPTH);

	// storage, no reset needed
	logic [DATA_W-1:0] data_mem [FIFO_DEPTH];
	logic [STRB_W-1:0] strb_mem [FIFO_DEPTH];

	// extra msb tells a full FIFO from an empty one
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;

	////////////////////////////////////////
	// write side
	////////////////////////////////////////

	always_ff @(posedge AClk or negedge ARst) begin
		if (!ARst) begin
			wr_ptr <= '0;
		end else if (push) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge AClk) begin
		if (push) begin
			data_mem[wr_ptr[AW-1:0]] <= push_data;
			strb_mem[wr_ptr[AW-1:0]] <= push_strb;
		end
	end

	////////////////////////////////////////
	// read side
	////////////////////////////////////////

	always_ff @(posedge AClk or negedge ARst) begin
		if (!ARst) begin
			rd_ptr <= '0;
		end else if (pop) begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// head entry is visible with no read latency
	assign pop_data = data_mem[rd_ptr[AW-1:0]];
	assign pop_strb = strb_mem[rd_ptr[AW-1:0]];

	// flags from pointer compare
	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	// upstream must honour wdata_ready
	a_no_push_full: assert property (@(posedge AClk) disable iff (!ARst)
		push |-> !full);

	// W channel must check fifo_empty before popping
	a_no_pop_empty: assert property (@(posedge AClk) disable iff (!ARst)
		pop |-> !empty);

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the AXI write master testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module tb_axi_wr_master \
	--Mdir obj_dir -o sim_axi_wr_master \
	-f verilog.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/sim_axi_wr_master
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi
exit 0

/* sim/axi_slave_model.sv */
`timescale 1ns/10ps

module axi_slave_model #(
	parameter int ADDR_W    = 32,
	parameter int DATA_W    = 32,
	parameter int SEED      = 1,
	parameter int MAX_BEATS = 64
) (
	input  logic                          AClk,
	input  logic                          ARst,
	input  logic [axi_wr_pkg::ID_W-1:0]   AWID,
	input  logic [ADDR_W-1:0]             AWADDR,
	input  logic [axi_wr_pkg::LEN_W-1:0]  AWLEN,
	input  logic [axi_wr_pkg::SIZE_W-1:0] AWSIZE,
	input  axi_wr_pkg::burst_e            AWBURST,
	input  logic                          AWVALID,
	output logic                          AWREADY,
	input  logic [DATA_W-1:0]             WDATA,
	input  logic [DATA_W/8-1:0]           WSTRB,
	input  logic                          WLAST,
	input  logic                          WVALID,
	output logic                          WREADY,
	output logic [axi_wr_pkg::ID_W-1:0]   BID,
	output axi_wr_pkg::resp_e             BRESP,
	output logic                          BVALID,
	input  logic                          BREADY,
	input  axi_wr_pkg::resp_e             resp_sel
);

	localparam int AW_BITS = axi_wr_pkg::ID_W + ADDR_W + axi_wr_pkg::LEN_W + axi_wr_pkg::SIZE_W + 2;
	localparam int W_BITS  = DATA_W + DATA_W / 8 + 1;

	// captured traffic, read by the testbench
	logic [axi_wr_pkg::ID_W-1:0]   aw_id    [MAX_BEATS];
	logic [ADDR_W-1:0]             aw_addr  [MAX_BEATS];
	logic [axi_wr_pkg::LEN_W-1:0]  aw_len   [MAX_BEATS];
	logic [axi_wr_pkg::SIZE_W-1:0] aw_size  [MAX_BEATS];
	axi_wr_pkg::burst_e            aw_burst [MAX_BEATS];
	logic [DATA_W-1:0]             w_data   [MAX_BEATS];
	logic [DATA_W/8-1:0]           w_strb   [MAX_BEATS];
	logic                          w_last   [MAX_BEATS];

	int aw_count     = 0;
	int w_count      = 0;
	int stall_errors = 0;

	// B bookkeeping, one counter per writing process
	int b_req  = 0;
	int b_done = 0;
	int b_sent = 0;

	logic               aw_held = 1'b0;
	logic               w_held  = 1'b0;
	logic [AW_BITS-1:0] aw_snap;
	logic [W_BITS-1:0]  w_snap;
	integer             seed;
	logic [31:0]        stall;

	////////////////////////////////////////
	// monitor, sampled mid-cycle
	////////////////////////////////////////

	always @(negedge AClk) begin
		if (ARst) begin
			// payload must not move while stalled
			if (aw_held && (!AWVALID || {AWID, AWADDR, AWLEN, AWSIZE, AWBURST} !== aw_snap)) begin
				stall_errors++;
			end
			if (w_held && (!WVALID || {WDATA, WSTRB, WLAST} !== w_snap)) begin
				stall_errors++;
			end
			aw_held = AWVALID && !AWREADY;
			aw_snap = {AWID, AWADDR, AWLEN, AWSIZE, AWBURST};
			w_held  = WVALID && !WREADY;
			w_snap  = {WDATA, WSTRB, WLAST};

			if (AWVALID && AWREADY) begin
				aw_id[aw_count]    = AWID;
				aw_addr[aw_count]  = AWADDR;
				aw_len[aw_count]   = AWLEN;
				aw_size[aw_count]  = AWSIZE;
				aw_burst[aw_count] = AWBURST;
				aw_count++;
			end
			if (WVALID && WREADY) begin
				w_data[w_count] = WDATA;
				w_strb[w_count] = WSTRB;
				w_last[w_count] = WLAST;
				w_count++;
				if (WLAST) begin
					b_req++;
				end
			end
			if (BVALID && BREADY) begin
				b_done++;
			end
		end
	end

	////////////////////////////////////////
	// ready stalls and B response
	////////////////////////////////////////

	initial begin
		AWREADY = 1'b0;
		WREADY  = 1'b0;
		BVALID  = 1'b0;
		BID     = '0;
		BRESP   = axi_wr_pkg::OKAY;
		seed    = SEED;
		forever begin
			@(posedge AClk);
			#2;
			if (!ARst) begin
				AWREADY = 1'b0;
				WREADY  = 1'b0;
				BVALID  = 1'b0;
			end else begin
				// ready about three cycles in four
				stall   = $random(seed);
				AWREADY = stall[0] | stall[1];
				WREADY  = stall[2] | stall[3];
				if (BVALID && b_done == b_sent) begin
					BVALID = 1'b0;
				end else if (!BVALID && b_sent < b_req) begin
					BVALID = 1'b1;
					BID    = aw_id[aw_count-1];
					BRESP  = resp_sel;
					b_sent++;
				end
			end
		end
	end

endmodule

/* sim/tb_axi_wr_master.sv */
`timescale 1ns/10ps

module tb_axi_wr_master;

	localparam int CLK_PERIOD = 40;
	localparam int SEED       = 32'hf2a3;
	localparam int ADDR_W     = 32;
	localparam int DATA_W     = 32;
	localparam int STRB_W     = DATA_W / 8;
	localparam int FIFO_DEPTH = 16;
	localparam int WAIT_LIMIT = 400;

	logic                          AClk;
	logic                          ARst;
	logic                          cmd_valid;
	logic                          cmd_ready;
	logic [axi_wr_pkg::ID_W-1:0]   cmd_id;
	logic [ADDR_W-1:0]             cmd_addr;
	logic [axi_wr_pkg::LEN_W-1:0]  cmd_len;
	logic [axi_wr_pkg::SIZE_W-1:0] cmd_size;
	axi_wr_pkg::burst_e            cmd_burst;
	logic                          wdata_valid;
	logic                          wdata_ready;
	logic [DATA_W-1:0]             wdata_in;
	logic [STRB_W-1:0]             wstrb_in;
	logic [axi_wr_pkg::ID_W-1:0]   AWID;
	logic [ADDR_W-1:0]             AWADDR;
	logic [axi_wr_pkg::LEN_W-1:0]  AWLEN;
	logic [axi_wr_pkg::SIZE_W-1:0] AWSIZE;
	axi_wr_pkg::burst_e            AWBURST;
	logic                          AWVALID;
	logic                          AWREADY;
	logic [DATA_W-1:0]             WDATA;
	logic [STRB_W-1:0]             WSTRB;
	logic                          WLAST;
	logic                          WVALID;
	logic                          WREADY;
	logic [axi_wr_pkg::ID_W-1:0]   BID;
	axi_wr_pkg::resp_e             BRESP;
	logic                          BVALID;
	logic                          BREADY;
	logic                          rsp_valid;
	logic [axi_wr_pkg::ID_W-1:0]   rsp_id;
	axi_wr_pkg::resp_e             rsp_resp;
	axi_wr_pkg::resp_e             resp_sel;

	integer            seed;
	// expected lane history, zero after reset
	logic [DATA_W-1:0] lane_exp;
	logic [DATA_W-1:0] exp_data [$];
	logic [STRB_W-1:0] exp_strb [$];
	int                aw_next;
	int                w_next;

	axi_wr_master dut (
		.AClk (AClk), .ARst (ARst),
		.cmd_valid (cmd_valid), .cmd_ready (cmd_ready), .cmd_id (cmd_id),
		.cmd_addr (cmd_addr), .cmd_len (cmd_len), .cmd_size (cmd_size),
		.cmd_burst (cmd_burst),
		.wdata_valid (wdata_valid), .wdata_ready (wdata_ready),
		.wdata_in (wdata_in), .wstrb_in (wstrb_in),
		.AWID (AWID), .AWADDR (AWADDR), .AWLEN (AWLEN), .AWSIZE (AWSIZE),
		.AWBURST (AWBURST), .AWVALID (AWVALID), .AWREADY (AWREADY),
		.WDATA (WDATA), .WSTRB (WSTRB), .WLAST (WLAST), .WVALID (WVALID),
		.WREADY (WREADY),
		.BID (BID), .BRESP (BRESP), .BVALID (BVALID), .BREADY (BREADY),
		.rsp_valid (rsp_valid), .rsp_id (rsp_id), .rsp_resp (rsp_resp)
	);

	axi_slave_model #(
		.ADDR_W (ADDR_W),
		.DATA_W (DATA_W),
		.SEED   (SEED)
	) slave (
		.AClk (AClk), .ARst (ARst),
		.AWID (AWID), .AWADDR (AWADDR), .AWLEN (AWLEN), .AWSIZE (AWSIZE),
		.AWBURST (AWBURST), .AWVALID (AWVALID), .AWREADY (AWREADY),
		.WDATA (WDATA), .WSTRB (WSTRB), .WLAST (WLAST), .WVALID (WVALID),
		.WREADY (WREADY),
		.BID (BID), .BRESP (BRESP), .BVALID (BVALID), .BREADY (BREADY),
		.resp_sel (resp_sel)
	);

	always #(CLK_PERIOD / 2) AClk = ~AClk;

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected) begin
			$display("error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
			$display("RESULT: FAIL");
			$fatal(1, "value check failed");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("RESULT: FAIL");
		$fatal(1, "timed out after %0d cycles waiting for %s", WAIT_LIMIT, what);
	endtask

	task automatic next_cycle();
		@(posedge AClk);
		#2;
	endtask

	// byte lanes with a clear strobe repeat the last byte sent there
	function automatic logic [DATA_W-1:0] merge_lanes(input logic [DATA_W-1:0] hist,
		input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb);
		logic [DATA_W-1:0] mask;
		for (int i = 0; i < DATA_W; i++) begin
			mask[i] = strb[i / 8];
		end
		return (data & mask) | (hist & ~mask);
	endfunction

	task automatic send_cmd(input logic [axi_wr_pkg::ID_W-1:0] id,
		input logic [ADDR_W-1:0] addr, input logic [axi_wr_pkg::LEN_W-1:0] len,
		input logic [axi_wr_pkg::SIZE_W-1:0] size, input axi_wr_pkg::burst_e burst);
		int n;
		cmd_valid = 1'b1;
		cmd_id    = id;
		cmd_addr  = addr;
		cmd_len   = len;
		cmd_size  = size;
		cmd_burst = burst;
		n = 0;
		while (!cmd_ready && n < WAIT_LIMIT) begin
			next_cycle();
			n++;
		end
		if (!cmd_ready) begin
			report_timeout("cmd_ready");
		end
		next_cycle();
		cmd_valid = 1'b0;
	endtask

	task automatic push_beat(input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb);
		int n;
		wdata_valid = 1'b1;
		wdata_in    = data;
		wstrb_in    = strb;
		n = 0;
		while (!wdata_ready && n < WAIT_LIMIT) begin
			next_cycle();
			n++;
		end
		if (!wdata_ready) begin
			report_timeout("wdata_ready");
		end
		next_cycle();
		wdata_valid = 1'b0;
		exp_data.push_back(data);
		exp_strb.push_back(strb);
	endtask

	task automatic wait_rsp(input logic [axi_wr_pkg::ID_W-1:0] id, input axi_wr_pkg::resp_e resp);
		int n;
		n = 0;
		while (!rsp_valid && n < WAIT_LIMIT) begin
			next_cycle();
			n++;
		end
		if (!rsp_valid) begin
			report_timeout("rsp_valid");
		end
		check_value("rsp_id", 64'(rsp_id), 64'(id));
		check_value("rsp_resp", 64'(rsp_resp), 64'(resp));
		next_cycle();
		// report is a single-cycle pulse
		check_value("rsp_valid", 64'(rsp_valid), 64'(0));
	endtask

	task automatic check_aw(input logic [axi_wr_pkg::ID_W-1:0] id,
		input logic [ADDR_W-1:0] addr, input logic [axi_wr_pkg::LEN_W-1:0] len,
		input logic [axi_wr_pkg::SIZE_W-1:0] size, input axi_wr_pkg::burst_e burst);
		check_value("aw_count", 64'(slave.aw_count), 64'(aw_next + 1));
		check_value("AWID", 64'(slave.aw_id[aw_next]), 64'(id));
		check_value("AWADDR", 64'(slave.aw_addr[aw_next]), 64'(addr));
		check_value("AWLEN", 64'(slave.aw_len[aw_next]), 64'(len));
		check_value("AWSIZE", 64'(slave.aw_size[aw_next]), 64'(size));
		check_value("AWBURST", 64'(slave.aw_burst[aw_next]), 64'(burst));
		aw_next++;
	endtask

	task automatic check_beats(input int beats);
		logic [DATA_W-1:0] data;
		logic [STRB_W-1:0] strb;
		check_value("w_count", 64'(slave.w_count), 64'(w_next + beats));
		for (int i = 0; i < beats; i++) begin
			data     = exp_data.pop_front();
			strb     = exp_strb.pop_front();
			lane_exp = merge_lanes(lane_exp, data, strb);
			check_value("WDATA", 64'(slave.w_data[w_next]), 64'(lane_exp));
			check_value("WSTRB", 64'(slave.w_strb[w_next]), 64'(strb));
			check_value("WLAST", 64'(slave.w_last[w_next]), 64'(i == beats - 1));
			w_next++;
		end
	endtask

	////////////////////////////////////////
	// directed tests
	////////////////////////////////////////

	task automatic reset_values();
		check_value("AWVALID", 64'(AWVALID), 64'(0));
		check_value("WVALID", 64'(WVALID), 64'(0));
		check_value("WLAST", 64'(WLAST), 64'(0));
		check_value("BREADY", 64'(BREADY), 64'(0));
		check_value("rsp_valid", 64'(rsp_valid), 64'(0));
		check_value("cmd_ready", 64'(cmd_ready), 64'(1));
		check_value("wdata_ready", 64'(wdata_ready), 64'(1));
	endtask

	task automatic single_write();
		push_beat(32'ha5a5_1234, 4'hf);
		send_cmd(4'h3, 32'h0000_1000, 8'd0, 3'd2, axi_wr_pkg::INCR);
		wait_rsp(4'h3, axi_wr_pkg::OKAY);
		check_aw(4'h3, 32'h0000_1000, 8'd0, 3'd2, axi_wr_pkg::INCR);
		check_beats(1);
	endtask

	task automatic burst_write();
		logic [DATA_W-1:0] data;
		// data follows the command here
		send_cmd(4'h5, 32'h0000_2000, 8'd3, 3'd2, axi_wr_pkg::INCR);
		for (int i = 0; i < 4; i++) begin
			data = $random(seed);
			push_beat(data, 4'hf);
		end
		wait_rsp(4'h5, axi_wr_pkg::OKAY);
		check_aw(4'h5, 32'h0000_2000, 8'd3, 3'd2, axi_wr_pkg::INCR);
		check_beats(4);
		check_value("stall_errors", 64'(slave.stall_errors), 64'(0));
	endtask

	task automatic strobe_merge();
		logic [STRB_W-1:0] strb_list [6] = '{4'b0001, 4'b1010, 4'b0000,
			4'b0110, 4'b1111, 4'b1000};
		logic [DATA_W-1:0] data;
		for (int i = 0; i < 6; i++) begin
			data = $random(seed);
			push_beat(data, strb_list[i]);
		end
		send_cmd(4'ha, 32'h0000_3000, 8'd5, 3'd2, axi_wr_pkg::FIXED);
		wait_rsp(4'ha, axi_wr_pkg::OKAY);
		check_aw(4'ha, 32'h0000_3000, 8'd5, 3'd2, axi_wr_pkg::FIXED);
		check_beats(6);
	endtask

	task automatic error_and_preload();
		logic [DATA_W-1:0] data;
		// two beats for the first command, three for the second
		for (int i = 0; i < 5; i++) begin
			data = $random(seed);
			push_beat(data, (i == 3) ? 4'b0101 : 4'hf);
		end
		resp_sel = axi_wr_pkg::SLVERR;
		send_cmd(4'h7, 32'h0000_4000, 8'd1, 3'd2, axi_wr_pkg::INCR);
		wait_rsp(4'h7, axi_wr_pkg::SLVERR);
		check_aw(4'h7, 32'h0000_4000, 8'd1, 3'd2, axi_wr_pkg::INCR);
		check_beats(2);
		resp_sel = axi_wr_pkg::OKAY;
		send_cmd(4'h9, 32'h0000_5008, 8'd2, 3'd2, axi_wr_pkg::WRAP);
		wait_rsp(4'h9, axi_wr_pkg::OKAY);
		check_aw(4'h9, 32'h0000_5008, 8'd2, 3'd2, axi_wr_pkg::WRAP);
		check_beats(3);
	endtask

	task automatic fifo_full();
		logic [DATA_W-1:0] data;
		for (int i = 0; i < FIFO_DEPTH; i++) begin
			data = $random(seed);
			push_beat(data, 4'hf);
		end
		check_value("wdata_ready", 64'(wdata_ready), 64'(0));
		send_cmd(4'hc, 32'h0000_6000, 8'(FIFO_DEPTH - 1), 3'd2, axi_wr_pkg::INCR);
		wait_rsp(4'hc, axi_wr_pkg::OKAY);
		check_value("wdata_ready", 64'(wdata_ready), 64'(1));
		check_aw(4'hc, 32'h0000_6000, 8'(FIFO_DEPTH - 1), 3'd2, axi_wr_pkg::INCR);
		check_beats(FIFO_DEPTH);
	endtask

	initial begin
		AClk        = 1'b0;
		ARst        = 1'b0;
		cmd_valid   = 1'b0;
		cmd_id      = '0;
		cmd_addr    = '0;
		cmd_len     = '0;
		cmd_size    = '0;
		cmd_burst   = axi_wr_pkg::INCR;
		wdata_valid = 1'b0;
		wdata_in    = '0;
		wstrb_in    = '0;
		resp_sel    = axi_wr_pkg::OKAY;
		seed        = SEED;
		lane_exp    = '0;
		aw_next     = 0;
		w_next      = 0;
		repeat (4) @(posedge AClk);
		#2;
		ARst = 1'b1;

		reset_values();
		single_write();
		burst_write();
		strobe_merge();
		error_and_preload();
		fifo_full();
		check_value("stall_errors", 64'(slave.stall_errors), 64'(0));

		$display("RESULT: PASS");
		$finish;
	end

endmodule

/* verilog.f */
hw/axi_wr_pkg.sv
hw/wdata_fifo.sv
hw/axi_w_channel.sv
hw/axi_wr_ctrl.sv
hw/axi_wr_master.sv
sim/axi_slave_model.sv
sim/tb_axi_wr_master.sv
